/* aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvCorePkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  result
);

    logic [4:0] shamt;
    logic ltSigned;
    logic ltUnsigned;

    assign shamt = b[4:0];    // Only five bits count for RV32
    assign ltSigned = ($signed(a) < $signed(b));
    assign ltUnsigned = (a < b);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {31'b0, ltSigned};
            aluSltu: result = {31'b0, ltUnsigned};
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt;    // Sign fill
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import rvCorePkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  word_t  instr,
    input  logic   wbAck,
    output logic   wbCyc,
    output logic   wbStb,
    output logic   wbWe,
    output logic   irWrite,
    output logic   mdrWrite,
    output logic   pcWrite,
    output logic   regWrite,
    output logic   aluResWrite,
    output logic   addrFromAlu,
    output logic   aluSrcImm,
    output logic   wbFromMem,
    output aluOp_t aluOp
);

    ctrlState_t state;
    logic busActive;    // Wishbone cycle open

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic isRegReg;
    logic isRegImm;
    logic isLoad;
    logic isStore;
    logic validOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign isRegReg = (opcode == opRegReg);
    assign isRegImm = (opcode == opRegImm);
    assign isLoad   = (opcode == opLoad);
    assign isStore  = (opcode == opStore);

    // Legality check and ALU operation select
    always_comb begin
        validOp = 1'b0;
        aluOp = aluAdd;    // Address calculation for LW and SW
        if (isRegReg) begin
            validOp = (funct7 == funct7Base) ||
                      ((funct7 == funct7Alt) && (funct3 == f3AddSub || funct3 == f3SrlSra));
        end else if (isRegImm) begin
            case (funct3)
                f3Sll:    validOp = (funct7 == funct7Base);
                f3SrlSra: validOp = (funct7 == funct7Base) || (funct7 == funct7Alt);
                default:  validOp = 1'b1;
            endcase
        end else if (isLoad || isStore) begin
            validOp = (funct3 == f3Word);
        end

        if (isRegReg || isRegImm) begin
            case (funct3)
                f3AddSub: aluOp = (isRegReg && funct7 == funct7Alt) ? aluSub : aluAdd;
                f3Sll:    aluOp = aluSll;
                f3Slt:    aluOp = aluSlt;
                f3Sltu:   aluOp = aluSltu;
                f3Xor:    aluOp = aluXor;
                f3SrlSra: aluOp = (funct7 == funct7Alt) ? aluSra : aluSrl;
                f3Or:     aluOp = aluOr;
                f3And:    aluOp = aluAnd;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            busActive <= 1'b0;
        end else begin
            case (state)
                stFetch: begin
                    if (!busActive) begin
                        busActive <= 1'b1;    // Only the first fetch after reset
                    end else if (wbAck) begin
                        busActive <= 1'b0;
                        state <= stDecode;
                    end
                end
                stDecode: begin
                    state <= validOp ? stExecute : stWriteback;
                end
                stExecute: begin
                    if (isLoad || isStore) begin
                        busActive <= 1'b1;
                        state <= stMemory;
                    end else begin
                        state <= stWriteback;
                    end
                end
                stMemory: begin
                    if (wbAck) begin
                        busActive <= 1'b0;
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    busActive <= 1'b1;    // Next fetch opens here
                    state <= stFetch;
                end
                default: begin
                    busActive <= 1'b0;
                    state <= stFetch;
                end
            endcase
        end
    end

    assign wbCyc = busActive;
    assign wbStb = busActive;
    assign wbWe  = busActive && (state == stMemory) && isStore;

    assign irWrite     = (state == stFetch) && busActive && wbAck;
    assign mdrWrite    = (state == stMemory) && busActive && wbAck && isLoad;
    assign pcWrite     = (state == stWriteback);
    assign regWrite    = (state == stWriteback) && validOp && !isStore;    // ALU ops and LW
    assign aluResWrite = (state == stExecute);
    assign addrFromAlu = (state == stMemory);
    assign aluSrcImm   = !isRegReg;
    assign wbFromMem   = isLoad;

endmodule

`default_nettype wire

/* coreChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module coreChecker import rvCorePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wbCyc,
    input  logic      wbStb,
    input  logic      wbWe,
    input  wordAddr_t wbAdr,
    input  word_t     wbDatO,
    input  logic [3:0] wbSel,
    input  logic      wbAck,
    input  word_t     wbDatI,
    output int        errorCount,
    output int        fetchCount,
    output int        storeCount
);

    word_t     modelRegs [32];
    word_t     modelPc;
    logic      expectData;    // LW or SW still owes a data cycle
    logic      expectStore;
    wordAddr_t dataAdr;
    word_t     storeData;
    regIdx_t   loadRd;

    task automatic reportMismatch(input string name, input word_t got, input word_t expected);
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        errorCount++;
    endtask

    task automatic protocolError(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errorCount++;
    endtask

    function automatic word_t aluResult(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t r;
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic writeReg(input regIdx_t rd, input word_t value);
        if (rd != 5'd0) begin    // x0 stays zero
            modelRegs[rd] = value;
        end
    endtask

    task automatic checkFetch();
        word_t ins;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t immI;
        word_t immS;
        word_t sum;
        ins = wbDatI;
        f3 = ins[14:12];
        f7 = ins[31:25];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        if (wbWe) begin
            protocolError("unexpected write cycle where an instruction fetch was due");
        end else begin
            if (wbAdr !== modelPc[31:2]) begin
                reportMismatch("wbAdr", {2'b00, wbAdr}, {2'b00, modelPc[31:2]});
            end
            fetchCount++;
            modelPc = modelPc + 32'd4;
            case (ins[6:0])
                opRegReg: begin
                    if (f7 == funct7Base || (f7 == funct7Alt && (f3 == 3'b000 || f3 == 3'b101))) begin
                        writeReg(ins[11:7], aluResult(f3, f7[5], modelRegs[ins[19:15]],
                                                      modelRegs[ins[24:20]]));
                    end
                end
                opRegImm: begin
                    if ((f3 != 3'b001 && f3 != 3'b101) || f7 == funct7Base ||
                        (f3 == 3'b101 && f7 == funct7Alt)) begin
                        writeReg(ins[11:7], aluResult(f3, f3 == 3'b101 && f7[5],
                                                      modelRegs[ins[19:15]], immI));
                    end
                end
                opLoad, opStore: begin
                    if (f3 == 3'b010) begin
                        expectData = 1'b1;
                        expectStore = (ins[6:0] == opStore);
                        sum = modelRegs[ins[19:15]] + (expectStore ? immS : immI);
                        dataAdr = sum[31:2];    // Low two bits dropped
                        storeData = modelRegs[ins[24:20]];
                        loadRd = ins[11:7];
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic checkData();
        expectData = 1'b0;
        if (expectStore && !wbWe) begin
            protocolError("missing SW write cycle, a read cycle came instead");
        end else if (!expectStore && wbWe) begin
            protocolError("unexpected write cycle where the LW read was due");
        end else begin
            if (wbAdr !== dataAdr) begin
                reportMismatch("wbAdr", {2'b00, wbAdr}, {2'b00, dataAdr});
            end
            if (expectStore) begin
                if (wbDatO !== storeData) begin
                    reportMismatch("wbDatO", wbDatO, storeData);
                end
                if (wbSel !== 4'b1111) begin
                    reportMismatch("wbSel", {28'd0, wbSel}, 32'h0000_000f);
                end
                storeCount++;
            end else begin
                writeReg(loadRd, wbDatI);
            end
        end
    endtask

    // Falling edge sampling, bus and responder are settled here
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                modelRegs[i] = '0;
            end
            modelPc = resetPc;
            expectData = 1'b0;
            expectStore = 1'b0;
            errorCount = 0;
            fetchCount = 0;
            storeCount = 0;
        end else if (wbCyc && wbStb && wbAck) begin
            if (expectData) begin
                checkData();
            end else begin
                checkFetch();
            end
        end
    end

endmodule

`default_nettype wire

/* coreDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module coreDatapath import rvCorePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      irWrite,
    input  logic      mdrWrite,
    input  logic      pcWrite,
    input  logic      regWrite,
    input  logic      aluResWrite,
    input  logic      addrFromAlu,
    input  logic      aluSrcImm,
    input  logic      wbFromMem,
    input  aluOp_t    aluOp,
    input  word_t     wbDatI,
    output word_t     instr,
    output wordAddr_t wbAdr,
    output word_t     wbDatO
);

    word_t pc;
    word_t ir;
    word_t mdr;
    word_t regA;
    word_t regB;
    word_t immReg;
    word_t aluRes;

    word_t rs1Data;
    word_t rs2Data;
    word_t immNext;
    word_t aluB;
    word_t aluOut;
    word_t writeData;

    regIdx_t rs1Idx;
    regIdx_t rs2Idx;
    regIdx_t rdIdx;

    assign rs1Idx = ir[19:15];
    assign rs2Idx = ir[24:20];
    assign rdIdx  = ir[11:7];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (pcWrite) begin
            pc <= pc + 32'd4;    // No branches, so always sequential
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            ir <= wbDatI;
        end
        if (mdrWrite) begin
            mdr <= wbDatI;
        end
        if (aluResWrite) begin
            aluRes <= aluOut;
        end
        regA <= rs1Data;    // IR holds still after fetch
        regB <= rs2Data;
        immReg <= immNext;
    end

    // S format for stores, I format otherwise
    assign immNext = (ir[6:0] == opStore) ? {{20{ir[31]}}, ir[31:25], ir[11:7]}
                                          : {{20{ir[31]}}, ir[31:20]};

    assign aluB = aluSrcImm ? immReg : regB;
    assign writeData = wbFromMem ? mdr : aluRes;

    registerFile regs (
        .clk         (clk),
        .reset       (reset),
        .rs1         (rs1Idx),
        .rs2         (rs2Idx),
        .rd          (rdIdx),
        .writeEnable (regWrite),
        .writeData   (writeData),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data)
    );

    aluUnit alu (
        .a      (regA),
        .b      (aluB),
        .op     (aluOp),
        .result (aluOut)
    );

    assign instr  = ir;
    assign wbAdr  = addrFromAlu ? aluRes[31:2] : pc[31:2];    // Word address
    assign wbDatO = regB;    // Store data from rs2

endmodule

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile import rvCorePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t rs1,
    input  regIdx_t rs2,
    input  regIdx_t rd,
    input  logic    writeEnable,
    input  word_t   writeData,
    output word_t   rs1Data,
    output word_t   rs2Data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != '0) begin    // x0 stays zero
            regs[rd] <= writeData;
        end
    end

    // Asynchronous read
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tbRvCore -o simRvCore

# Keep running past assertion errors so the testbench reaches its report
./obj_dir/simRvCore +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"

/* rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore import rvCorePkg::*; (
    input  logic      clk,
    input  logic      reset,
    output logic      wbCyc,
    output logic      wbStb,
    output logic      wbWe,
    output wordAddr_t wbAdr,
    output word_t     wbDatO,
    output logic [3:0] wbSel,
    input  logic      wbAck,
    input  word_t     wbDatI
);

    word_t  instr;
    aluOp_t aluOp;
    logic   irWrite;
    logic   mdrWrite;
    logic   pcWrite;
    logic   regWrite;
    logic   aluResWrite;
    logic   addrFromAlu;
    logic   aluSrcImm;
    logic   wbFromMem;

    assign wbSel = 4'b1111;    // Word accesses only

    controlUnit ctrl (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .wbAck       (wbAck),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .irWrite     (irWrite),
        .mdrWrite    (mdrWrite),
        .pcWrite     (pcWrite),
        .regWrite    (regWrite),
        .aluResWrite (aluResWrite),
        .addrFromAlu (addrFromAlu),
        .aluSrcImm   (aluSrcImm),
        .wbFromMem   (wbFromMem),
        .aluOp       (aluOp)
    );

    coreDatapath datapath (
        .clk         (clk),
        .reset       (reset),
        .irWrite     (irWrite),
        .mdrWrite    (mdrWrite),
        .pcWrite     (pcWrite),
        .regWrite    (regWrite),
        .aluResWrite (aluResWrite),
        .addrFromAlu (addrFromAlu),
        .aluSrcImm   (aluSrcImm),
        .wbFromMem   (wbFromMem),
        .aluOp       (aluOp),
        .wbDatI      (wbDatI),
        .instr       (instr),
        .wbAdr       (wbAdr),
        .wbDatO      (wbDatO)
    );

endmodule

`default_nettype wire

/* rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    localparam int xlen = 32;
    localparam int regIdxWidth = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-3:0] wordAddr_t;    // Byte address minus the low two bits
    typedef logic [regIdxWidth-1:0] regIdx_t;

    // Major opcodes
    localparam logic [6:0] opRegReg = 7'b0110011;
    localparam logic [6:0] opRegImm = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;

    // funct3 fields
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;    // LW and SW width

    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt  = 7'b0100000;    // SUB, SRA, SRAI

    localparam word_t resetPc = 32'h0000_0000;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOp_t;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback
    } ctrlState_t;

endpackage

`default_nettype wire

/* rvCore_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreProps import rvCorePkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      wbCyc,
    input logic      wbStb,
    input logic      wbWe,
    input wordAddr_t wbAdr,
    input word_t     wbDatO,
    input logic      wbAck
);

    int failCount = 0;    // Read by the testbench at the end

    stbInsideCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
        else begin
            $error("wbStb high while wbCyc is low");
            failCount++;
        end

    // Request held until the slave acks
    holdWhileWaiting: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe))
        else begin
            $error("Bus request changed before wbAck");
            failCount++;
        end

    writeDataHeld: assert property (@(posedge clk) disable iff (reset)
        wbStb && wbWe && !wbAck |=> $stable(wbDatO))
        else begin
            $error("wbDatO changed during a write before wbAck");
            failCount++;
        end

    dropAfterAck: assert property (@(posedge clk) disable iff (reset)
        wbStb && wbAck |=> !wbStb)
        else begin
            $error("wbStb still high in the cycle after wbAck");
            failCount++;
        end

    idleAfterReset: assert property (@(posedge clk) reset |=> !wbCyc)
        else begin
            $error("wbCyc high right after reset");
            failCount++;
        end

endmodule

`default_nettype wire

/* tbRvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRvCore import rvCorePkg::*; ();

    localparam int numInstr = 600;
    localparam int resetCycles = 10;
    localparam int timeoutNs = numInstr * 20 * 10;    // Instructions x cycles x period

    logic      clk;
    logic      reset;
    logic      wbCyc;
    logic      wbStb;
    logic      wbWe;
    wordAddr_t wbAdr;
    word_t     wbDatO;
    logic [3:0] wbSel;
    logic      wbAck;
    word_t     wbDatI;
    int        errorCount;
    int        fetchCount;
    int        storeCount;

    word_t lfsrState = 32'hfcab_ec2c;

    rvCore UUT (
        .clk    (clk),
        .reset  (reset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatO (wbDatO),
        .wbSel  (wbSel),
        .wbAck  (wbAck),
        .wbDatI (wbDatI)
    );

    coreChecker checkUnit (
        .clk        (clk),
        .reset      (reset),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbDatO     (wbDatO),
        .wbSel      (wbSel),
        .wbAck      (wbAck),
        .wbDatI     (wbDatI),
        .errorCount (errorCount),
        .fetchCount (fetchCount),
        .storeCount (storeCount)
    );

    bind rvCore rvCoreProps props (
        .clk    (clk),
        .reset  (reset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatO (wbDatO),
        .wbAck  (wbAck)
    );

    // Taps 32, 22, 2, 1
    function automatic word_t lfsrNext(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t randBits(input int count);
        word_t r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic word_t makeInstr();
        word_t kind;
        word_t rd;
        word_t rs1;
        word_t rs2;
        word_t f3;
        word_t imm;
        word_t alt;
        logic [6:0] f7;
        word_t ins;
        kind = randBits(4);
        rd = randBits(3);    // Registers x0 to x7 so values get reused
        rs1 = randBits(3);
        rs2 = randBits(3);
        f3 = randBits(3);
        imm = randBits(12);
        alt = randBits(1);
        f7 = alt[0] ? funct7Alt : funct7Base;
        if (kind < 32'd6) begin    // Stores weighted heavily
            ins = {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], opStore};
        end else if (kind < 32'd8) begin
            ins = {imm[11:0], rs1[4:0], f3Word, rd[4:0], opLoad};
        end else if (kind < 32'd12) begin
            if (f3[2:0] != f3AddSub && f3[2:0] != f3SrlSra) begin
                f7 = funct7Base;
            end
            ins = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opRegReg};
        end else if (f3[2:0] == f3Sll || f3[2:0] == f3SrlSra) begin
            if (f3[2:0] == f3Sll) begin
                f7 = funct7Base;
            end
            ins = {f7, imm[4:0], rs1[4:0], f3[2:0], rd[4:0], opRegImm};    // Shift by shamt
        end else begin
            ins = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opRegImm};
        end
        return ins;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory responder with 0 to 3 wait cycles per access
    initial begin : responder
        word_t delayLeft;
        logic busy;
        wbAck = 1'b0;
        wbDatI = '0;
        busy = 1'b0;
        delayLeft = '0;
        forever begin
            @(posedge clk);
            #1;
            if (reset || wbAck) begin
                wbAck = 1'b0;    // Master closes the cycle on the ack edge
                busy = 1'b0;
            end else if (wbCyc && wbStb) begin
                if (!busy) begin
                    busy = 1'b1;
                    delayLeft = randBits(2);
                end
                if (delayLeft == 32'd0) begin
                    wbAck = 1'b1;
                    if (!wbWe) begin
                        wbDatI = makeInstr();    // Also serves as load data
                    end
                end else begin
                    delayLeft = delayLeft - 32'd1;
                end
            end
        end
    end

    initial begin : watchdog
        #(timeoutNs);
        $display("Timeout: only %0d of %0d fetches completed before the watchdog expired",
                 fetchCount, numInstr);
        $display("Something failed");
        $finish;
    end

    initial begin : mainSequence
        int assertFails;
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        while (fetchCount < numInstr) begin
            @(posedge clk);
        end
        assertFails = UUT.props.failCount;
        $display("Fetches %0d, stores checked %0d, checker errors %0d, assertion failures %0d",
                 fetchCount, storeCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rvCorePkg.sv
aluUnit.sv
registerFile.sv
controlUnit.sv
coreDatapath.sv
rvCore.sv
rvCore_props.sv
coreChecker.sv
tbRvCore.sv
